// ==== Makefile ====
TOP = batCpuTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f list.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== hw/aluUnit.sv ====
module aluUnit (
	input batPkg::aluOp_t aluOp,
	input batPkg::data_t a,
	input batPkg::data_t b,
	output batPkg::data_t aluResult,
	output logic aluZero
);

	// a is rd, b is rs
	always_comb
	begin
		case (aluOp)
			batPkg::ALU_ADD:
			begin
				aluResult = a + b;
			end
			batPkg::ALU_SUB:
			begin
				// two's complement wrap
				aluResult = a - b;
			end
			batPkg::ALU_AND:
			begin
				aluResult = a & b;
			end
			batPkg::ALU_OR:
			begin
				aluResult = a | b;
			end
			batPkg::ALU_XOR:
			begin
				aluResult = a ^ b;
			end
			batPkg::ALU_INC:
			begin
				aluResult = a + batPkg::data_t'(1);
			end
			batPkg::ALU_MOV:
			begin
				aluResult = b;
			end
			default:
			begin
				// undefined codes leave rd as it was
				aluResult = a;
			end
		endcase
	end

	assign aluZero = (aluResult == '0);

endmodule

// ==== hw/batCpu.sv ====
module batCpu (
	input logic CLK,
	input logic rstN,
	input logic run,
	input logic hostReq,
	input batPkg::memReq_t hostReqData,
	output logic hostAck,
	output batPkg::memRsp_t hostRsp,
	output logic halted,
	output batPkg::data_t outValue
);

	// cpu memory port
	logic cpuReq;
	logic cpuAck;
	batPkg::memReq_t cpuReqData;
	batPkg::memRsp_t cpuRsp;

	// register file control and data
	batPkg::regIdx_t rdSel;
	batPkg::regIdx_t rsSel;
	logic regWrite;
	logic regInc;
	batPkg::data_t regWrData;
	batPkg::data_t rdData;
	batPkg::data_t rsData;

	// alu
	batPkg::aluOp_t aluOp;
	batPkg::data_t aluResult;
	logic aluZero;

	// ram side of the arbiter
	logic memEn;
	logic memWe;
	batPkg::addr_t memAddr;
	batPkg::word_t memWrData;
	batPkg::word_t memRdData;

	microController microController_i (
		.CLK(CLK),
		.rstN(rstN),
		.run(run),
		.cpuAck(cpuAck),
		.cpuRsp(cpuRsp),
		.rsData(rsData),
		.rdData(rdData),
		.aluResult(aluResult),
		.aluZero(aluZero),
		.cpuReq(cpuReq),
		.cpuReqData(cpuReqData),
		.rdSel(rdSel),
		.rsSel(rsSel),
		.regWrite(regWrite),
		.regInc(regInc),
		.regWrData(regWrData),
		.aluOp(aluOp),
		.halted(halted)
	);

	registerFile registerFile_i (
		.CLK(CLK),
		.rstN(rstN),
		.rdSel(rdSel),
		.rsSel(rsSel),
		.regWrite(regWrite),
		.regInc(regInc),
		.regWrData(regWrData),
		.rdData(rdData),
		.rsData(rsData),
		.outValue(outValue)
	);

	// rd on the a side, rs on the b side
	aluUnit aluUnit_i (
		.aluOp(aluOp),
		.a(rdData),
		.b(rsData),
		.aluResult(aluResult),
		.aluZero(aluZero)
	);

	memArbiter memArbiter_i (
		.CLK(CLK),
		.rstN(rstN),
		.cpuReq(cpuReq),
		.cpuReqData(cpuReqData),
		.hostReq(hostReq),
		.hostReqData(hostReqData),
		.memRdData(memRdData),
		.cpuAck(cpuAck),
		.hostAck(hostAck),
		.cpuRsp(cpuRsp),
		.hostRsp(hostRsp),
		.memEn(memEn),
		.memWe(memWe),
		.memAddr(memAddr),
		.memWrData(memWrData)
	);

	unifiedMemory unifiedMemory_i (
		.CLK(CLK),
		.memEn(memEn),
		.memWe(memWe),
		.memAddr(memAddr),
		.memWrData(memWrData),
		.memRdData(memRdData)
	);

endmodule

// ==== hw/batPkg.sv ====
package batPkg;

	// datapath widths
	localparam int DATA_W = 8;
	localparam int ADDR_W = 8;
	localparam int WORD_W = 16;
	localparam int REG_IDX_W = 3;
	localparam int ALU_OP_W = 5;
	localparam int OPCODE_W = 4;

	// storage sizes
	localparam int MEM_DEPTH = 256;
	localparam int NUM_REGS = 8;
	// register 7 doubles as the output port
	localparam int OUT_REG = 7;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_IDX_W-1:0] regIdx_t;
	typedef logic [ALU_OP_W-1:0] aluOp_t;
	typedef logic [OPCODE_W-1:0] opcode_t;

	// opcodes live in instruction bits 15..12
	localparam opcode_t OP_LDI = 4'h1;
	localparam opcode_t OP_LD = 4'h2;
	localparam opcode_t OP_ST = 4'h3;
	localparam opcode_t OP_JMP = 4'h4;
	localparam opcode_t OP_JZ = 4'h5;
	localparam opcode_t OP_JNZ = 4'h6;
	localparam opcode_t OP_ALU = 4'h7;
	localparam opcode_t OP_HLT = 4'hF;

	// alu operation, instruction bits 11..7
	localparam aluOp_t ALU_ADD = 5'd0;
	localparam aluOp_t ALU_SUB = 5'd1;
	localparam aluOp_t ALU_AND = 5'd2;
	localparam aluOp_t ALU_OR = 5'd3;
	localparam aluOp_t ALU_XOR = 5'd4;
	localparam aluOp_t ALU_INC = 5'd30;
	localparam aluOp_t ALU_MOV = 5'd31;

	// controller micro-steps
	typedef enum logic [2:0] {FETCH, WAITFETCH, DECODE, MEMOP, WAITMEM, HALT} uState_t;

	// request side of a memory port, held stable while req is high
	typedef struct packed {
		addr_t addr;
		word_t wrData;
		logic write;
	} memReq_t;

	// response side, valid while ack is high
	typedef struct packed {
		word_t rdData;
	} memRsp_t;

endpackage

// ==== hw/memArbiter.sv ====
module memArbiter (
	input logic CLK,
	input logic rstN,
	input logic cpuReq,
	input batPkg::memReq_t cpuReqData,
	input logic hostReq,
	input batPkg::memReq_t hostReqData,
	input batPkg::word_t memRdData,
	output logic cpuAck,
	output logic hostAck,
	output batPkg::memRsp_t cpuRsp,
	output batPkg::memRsp_t hostRsp,
	output logic memEn,
	output logic memWe,
	output batPkg::addr_t memAddr,
	output batPkg::word_t memWrData
);

	// grant steps: access, capture, then hold ack until req falls
	typedef enum logic [1:0] {ARB_IDLE, ARB_ACCESS, ARB_CAPTURE, ARB_HOLD} arbState_t;

	arbState_t state;
	// owner of the current grant, also the last one granted
	logic lastHost;
	logic ackQ;
	logic ownerReq;
	batPkg::memReq_t selReq;
	batPkg::word_t rdDataQ;

	assign selReq = lastHost ? hostReqData : cpuReqData;
	assign ownerReq = lastHost ? hostReq : cpuReq;

	// memory only sees the granted peer
	assign memEn = (state == ARB_ACCESS);
	assign memWe = memEn && selReq.write;
	assign memAddr = selReq.addr;
	assign memWrData = selReq.wrData;

	assign cpuAck = ackQ && !lastHost;
	assign hostAck = ackQ && lastHost;
	assign cpuRsp.rdData = rdDataQ;
	assign hostRsp.rdData = rdDataQ;

	always_ff @(posedge CLK)
	begin
		if (!rstN)
		begin
			state <= ARB_IDLE;
			lastHost <= 1'b1;
			ackQ <= 1'b0;
		end
		else
		begin
			case (state)
				ARB_IDLE:
				begin
					// on contention the peer not served last goes first
					if (cpuReq || hostReq)
					begin
						lastHost <= hostReq && (!cpuReq || !lastHost);
						state <= ARB_ACCESS;
					end
				end
				ARB_ACCESS:
				begin
					state <= ARB_CAPTURE;
				end
				ARB_CAPTURE:
				begin
					ackQ <= 1'b1;
					state <= ARB_HOLD;
				end
				ARB_HOLD:
				begin
					// release once the requester lets go
					if (!ownerReq)
					begin
						ackQ <= 1'b0;
						state <= ARB_IDLE;
					end
				end
				default:
				begin
					state <= ARB_IDLE;
				end
			endcase
		end
	end

	// read word held steady through the ack phase
	always_ff @(posedge CLK)
	begin
		if (state == ARB_CAPTURE)
		begin
			rdDataQ <= memRdData;
		end
	end

endmodule

// ==== hw/microController.sv ====
module microController (
	input logic CLK,
	input logic rstN,
	input logic run,
	input logic cpuAck,
	input batPkg::memRsp_t cpuRsp,
	input batPkg::data_t rsData,
	input batPkg::data_t rdData,
	input batPkg::data_t aluResult,
	input logic aluZero,
	output logic cpuReq,
	output batPkg::memReq_t cpuReqData,
	output batPkg::regIdx_t rdSel,
	output batPkg::regIdx_t rsSel,
	output logic regWrite,
	output logic regInc,
	output batPkg::data_t regWrData,
	output batPkg::aluOp_t aluOp,
	output logic halted
);

	batPkg::uState_t state;
	batPkg::uState_t nextState;
	batPkg::addr_t pc;
	batPkg::addr_t mar;
	batPkg::word_t ir;
	logic zeroFlag;

	// instruction fields
	batPkg::opcode_t opcode;
	batPkg::addr_t irAddr;

	// one-hot micro-step enables
	logic marFromPc;
	logic marFromIr;
	logic irLoad;
	logic pcInc;
	logic pcLoad;
	logic pcClear;
	logic flagLoad;

	assign opcode = ir[15:12];
	assign irAddr = ir[7:0];
	assign aluOp = ir[11:7];

	// alu format puts rd in 5..3, every other format in 10..8
	assign rdSel = (opcode == batPkg::OP_ALU) ? ir[5:3] : ir[10:8];
	assign rsSel = ir[2:0];

	// a request is open for the whole wait state
	assign cpuReq = (state == batPkg::WAITFETCH) || (state == batPkg::WAITMEM);
	assign cpuReqData.addr = mar;
	// store data is rd, zero-extended to a full word
	assign cpuReqData.wrData = {8'h00, rdData};
	assign cpuReqData.write = (state == batPkg::WAITMEM) && (opcode == batPkg::OP_ST);

	assign halted = (state == batPkg::HALT);

	always_comb
	begin
		nextState = state;
		marFromPc = 1'b0;
		marFromIr = 1'b0;
		irLoad = 1'b0;
		pcInc = 1'b0;
		pcLoad = 1'b0;
		pcClear = 1'b0;
		flagLoad = 1'b0;
		regWrite = 1'b0;
		regInc = 1'b0;
		regWrData = irAddr;
		case (state)
			batPkg::FETCH:
			begin
				// idles here while run is low
				// and waits for the previous ack to fall
				if (run && !cpuAck)
				begin
					marFromPc = 1'b1;
					nextState = batPkg::WAITFETCH;
				end
			end
			batPkg::WAITFETCH:
			begin
				if (cpuAck)
				begin
					irLoad = 1'b1;
					pcInc = 1'b1;
					nextState = batPkg::DECODE;
				end
			end
			batPkg::DECODE:
			begin
				nextState = batPkg::FETCH;
				case (opcode)
					batPkg::OP_LDI:
					begin
						// immediate is the default write data
						regWrite = 1'b1;
					end
					batPkg::OP_LD, batPkg::OP_ST:
					begin
						nextState = batPkg::MEMOP;
					end
					batPkg::OP_JMP:
					begin
						pcLoad = 1'b1;
					end
					batPkg::OP_JZ:
					begin
						pcLoad = zeroFlag;
					end
					batPkg::OP_JNZ:
					begin
						pcLoad = !zeroFlag;
					end
					batPkg::OP_ALU:
					begin
						if (aluOp == batPkg::ALU_MOV)
						begin
							// plain register transfer, flag untouched
							regWrite = 1'b1;
							regWrData = rsData;
						end
						else if (aluOp == batPkg::ALU_INC)
						begin
							// rd counts up in place, alu only supplies the flag
							regInc = 1'b1;
							flagLoad = 1'b1;
						end
						else
						begin
							regWrite = 1'b1;
							regWrData = aluResult;
							flagLoad = 1'b1;
						end
					end
					batPkg::OP_HLT:
					begin
						nextState = batPkg::HALT;
					end
					default:
					begin
						// unknown opcodes fall through as nop
						nextState = batPkg::FETCH;
					end
				endcase
			end
			batPkg::MEMOP:
			begin
				// the fetch ack must be gone before a new request
				if (!cpuAck)
				begin
					marFromIr = 1'b1;
					nextState = batPkg::WAITMEM;
				end
			end
			batPkg::WAITMEM:
			begin
				if (cpuAck)
				begin
					// ld takes the low byte of the word
					if (opcode == batPkg::OP_LD)
					begin
						regWrite = 1'b1;
						regWrData = cpuRsp.rdData[7:0];
					end
					nextState = batPkg::FETCH;
				end
			end
			batPkg::HALT:
			begin
				// dropping run rewinds to pc 0 and idles
				if (!run)
				begin
					pcClear = 1'b1;
					nextState = batPkg::FETCH;
				end
			end
			default:
			begin
				nextState = batPkg::FETCH;
			end
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (!rstN)
		begin
			state <= batPkg::FETCH;
			pc <= '0;
			zeroFlag <= 1'b0;
		end
		else
		begin
			state <= nextState;
			if (pcClear)
			begin
				pc <= '0;
			end
			else if (pcLoad)
			begin
				pc <= irAddr;
			end
			else if (pcInc)
			begin
				pc <= pc + batPkg::addr_t'(1);
			end
			if (flagLoad)
			begin
				zeroFlag <= aluZero;
			end
		end
	end

	// mar and ir only matter once loaded by a micro-step
	always_ff @(posedge CLK)
	begin
		if (marFromPc)
		begin
			mar <= pc;
		end
		else if (marFromIr)
		begin
			mar <= irAddr;
		end
		if (irLoad)
		begin
			ir <= cpuRsp.rdData;
		end
	end

endmodule

// ==== hw/registerFile.sv ====
module registerFile (
	input logic CLK,
	input logic rstN,
	input batPkg::regIdx_t rdSel,
	input batPkg::regIdx_t rsSel,
	input logic regWrite,
	input logic regInc,
	input batPkg::data_t regWrData,
	output batPkg::data_t rdData,
	output batPkg::data_t rsData,
	output batPkg::data_t outValue
);

	// general registers, index 7 is OUT
	batPkg::data_t regs [batPkg::NUM_REGS];

	always_ff @(posedge CLK)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < batPkg::NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (regWrite)
		begin
			// a write wins over increment
			regs[rdSel] <= regWrData;
		end
		else if (regInc)
		begin
			// wraps past 255
			regs[rdSel] <= regs[rdSel] + batPkg::data_t'(1);
		end
	end

	// two asynchronous read ports
	assign rdData = regs[rdSel];
	assign rsData = regs[rsSel];

	// OUT register shown at the top level
	assign outValue = regs[batPkg::OUT_REG];

endmodule

// ==== hw/unifiedMemory.sv ====
module unifiedMemory (
	input logic CLK,
	input logic memEn,
	input logic memWe,
	input batPkg::addr_t memAddr,
	input batPkg::word_t memWrData,
	output batPkg::word_t memRdData
);

	// program and data share the same words
	batPkg::word_t mem [batPkg::MEM_DEPTH];

	always_ff @(posedge CLK)
	begin
		if (memEn)
		begin
			if (memWe)
			begin
				mem[memAddr] <= memWrData;
			end
			// old contents come out on a write cycle
			memRdData <= mem[memAddr];
		end
	end

endmodule

// ==== list.f ====
hw/batPkg.sv
hw/aluUnit.sv
hw/registerFile.sv
hw/unifiedMemory.sv
hw/memArbiter.sv
hw/microController.sv
hw/batCpu.sv
sim/batCpuTb.sv

// ==== sim/batCpuTb.sv ====
module batCpuTb;

	// worst case of 20 cycles per instruction summed over all runs, plus program loads
	// and host traffic, rounded up with a wide margin
	localparam int TIMEOUT_CYCLES = 20000;

	logic CLK;
	logic rstN;
	logic run;
	logic hostReq;
	batPkg::memReq_t hostReqData;
	logic hostAck;
	batPkg::memRsp_t hostRsp;
	logic halted;
	batPkg::data_t outValue;

	// program image built up before each run
	batPkg::word_t prog [batPkg::MEM_DEPTH];
	int progLen;
	int cycleCount;
	int unsigned seedKick;

	// alu codes in an array so random picks can index them
	batPkg::aluOp_t aluOps [7] = '{batPkg::ALU_ADD, batPkg::ALU_SUB, batPkg::ALU_AND,
		batPkg::ALU_OR, batPkg::ALU_XOR, batPkg::ALU_INC, batPkg::ALU_MOV};

	batCpu batCpu_i (
		.CLK(CLK),
		.rstN(rstN),
		.run(run),
		.hostReq(hostReq),
		.hostReqData(hostReqData),
		.hostAck(hostAck),
		.hostRsp(hostRsp),
		.halted(halted),
		.outValue(outValue)
	);

	initial
	begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// hang guard over the whole run
	initial
	begin
		cycleCount = 0;
		while (cycleCount < TIMEOUT_CYCLES)
		begin
			@(posedge CLK);
			cycleCount++;
		end
		$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Result: FAILED");
		$fatal(1, "simulation timed out");
	end

	task automatic checkEq(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		if (got !== expected)
		begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, expected);
			$display("Result: FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// reference results from the instruction set table with modulo 256 wrap
	function automatic batPkg::data_t aluExpect(input batPkg::aluOp_t op,
		input batPkg::data_t a, input batPkg::data_t b);
		case (op)
			batPkg::ALU_ADD: return a + b;
			batPkg::ALU_SUB: return a - b;
			batPkg::ALU_AND: return a & b;
			batPkg::ALU_OR: return a | b;
			batPkg::ALU_XOR: return a ^ b;
			batPkg::ALU_INC: return a + 8'd1;
			batPkg::ALU_MOV: return b;
			default: return a;
		endcase
	endfunction

	// opcode 15..12, register 10..8, address or immediate 7..0
	function automatic batPkg::word_t encodeImm(input batPkg::opcode_t op,
		input batPkg::regIdx_t r, input batPkg::data_t v);
		return {op, 1'b0, r, v};
	endfunction

	// alu op 11..7, rd 5..3, rs 2..0
	function automatic batPkg::word_t encodeAlu(input batPkg::aluOp_t op,
		input batPkg::regIdx_t rd, input batPkg::regIdx_t rs);
		return {batPkg::OP_ALU, op, 1'b0, rd, rs};
	endfunction

	task automatic appendWord(input batPkg::word_t w);
		prog[progLen] = w;
		progLen++;
	endtask

	// sample edges until ack reaches the wanted level
	task automatic waitHostAck(input logic level);
		@(posedge CLK);
		while (hostAck !== level)
		begin
			@(posedge CLK);
		end
	endtask

	task automatic hostWrite(input batPkg::addr_t addr, input batPkg::word_t data);
		@(posedge CLK);
		hostReqData.addr <= addr;
		hostReqData.wrData <= data;
		hostReqData.write <= 1'b1;
		hostReq <= 1'b1;
		waitHostAck(1'b1);
		hostReq <= 1'b0;
		// next request only after ack has fallen
		waitHostAck(1'b0);
	endtask

	task automatic hostRead(input batPkg::addr_t addr, output batPkg::word_t data);
		@(posedge CLK);
		hostReqData.addr <= addr;
		hostReqData.wrData <= '0;
		hostReqData.write <= 1'b0;
		hostReq <= 1'b1;
		waitHostAck(1'b1);
		// read word is valid while ack is high
		data = hostRsp.rdData;
		hostReq <= 1'b0;
		waitHostAck(1'b0);
	endtask

	// program goes in from address 0 while run is low
	task automatic loadProgram();
		for (int i = 0; i < progLen; i++)
		begin
			hostWrite(batPkg::addr_t'(i), prog[i]);
		end
		progLen = 0;
	endtask

	// start at pc 0, wait for HLT, then drop run to idle again
	task automatic runProgram(input logic guard, input batPkg::data_t poison);
		@(posedge CLK);
		run <= 1'b1;
		@(posedge CLK);
		while (!halted)
		begin
			if (guard)
			begin
				checkEq("outValue == poison", 16'(outValue == poison), 16'h0000);
			end
			@(posedge CLK);
		end
		run <= 1'b0;
		@(posedge CLK);
		while (halted)
		begin
			@(posedge CLK);
		end
	endtask

	// r7 counts up n times while r1 counts down through the loop body at address 3
	task automatic emitCountLoop(input batPkg::data_t n);
		appendWord(encodeImm(batPkg::OP_LDI, 3'd1, n));
		appendWord(encodeImm(batPkg::OP_LDI, 3'd2, 8'd1));
		appendWord(encodeImm(batPkg::OP_LDI, 3'd7, 8'd0));
		appendWord(encodeAlu(batPkg::ALU_INC, 3'd7, 3'd0));
		appendWord(encodeAlu(batPkg::ALU_SUB, 3'd1, 3'd2));
		appendWord(encodeImm(batPkg::OP_JNZ, 3'd0, 8'd3));
	endtask

	task automatic afterReset();
		batPkg::word_t got;
		checkEq("halted", 16'(halted), 16'h0000);
		checkEq("outValue", 16'(outValue), 16'h0000);
		checkEq("hostAck", 16'(hostAck), 16'h0000);
		hostWrite(8'hF0, 16'hA5C3);
		hostRead(8'hF0, got);
		checkEq("hostRsp.rdData", got, 16'hA5C3);
	endtask

	task automatic aluOperations();
		batPkg::data_t opA;
		batPkg::data_t opB;
		// operands chosen so every operation gives a different result
		opA = 8'hC5;
		opB = 8'h6A;
		for (int i = 0; i < 7; i++)
		begin
			appendWord(encodeImm(batPkg::OP_LDI, 3'd1, opA));
			appendWord(encodeImm(batPkg::OP_LDI, 3'd2, opB));
			appendWord(encodeAlu(aluOps[i], 3'd1, 3'd2));
			// copy the result out to OUT
			appendWord(encodeAlu(batPkg::ALU_MOV, 3'd7, 3'd1));
			appendWord(encodeImm(batPkg::OP_HLT, 3'd0, 8'd0));
			loadProgram();
			runProgram(1'b0, 8'h00);
			checkEq("outValue", 16'(outValue), 16'(aluExpect(aluOps[i], opA, opB)));
		end
	endtask

	task automatic loadStore();
		batPkg::word_t got;
		batPkg::data_t expected;
		// upper byte must be dropped by LD
		hostWrite(8'h80, 16'hAB57);
		hostWrite(8'h81, 16'hFFFF);
		expected = 8'h57 + 8'd1;
		appendWord(encodeImm(batPkg::OP_LD, 3'd3, 8'h80));
		appendWord(encodeAlu(batPkg::ALU_INC, 3'd3, 3'd0));
		appendWord(encodeImm(batPkg::OP_ST, 3'd3, 8'h81));
		appendWord(encodeAlu(batPkg::ALU_MOV, 3'd7, 3'd3));
		appendWord(encodeImm(batPkg::OP_HLT, 3'd0, 8'd0));
		loadProgram();
		runProgram(1'b0, 8'h00);
		hostRead(8'h81, got);
		checkEq("hostRsp.rdData", got, {8'h00, expected});
		checkEq("outValue", 16'(outValue), 16'(expected));
	endtask

	task automatic jumpsAndLoop();
		batPkg::data_t loops;
		loops = 8'd7;
		emitCountLoop(loops);
		// address 6 clears the flag so the JZ at 7 falls through
		appendWord(encodeAlu(batPkg::ALU_OR, 3'd2, 3'd2));
		appendWord(encodeImm(batPkg::OP_JZ, 3'd0, 8'd9));
		appendWord(encodeImm(batPkg::OP_JMP, 3'd0, 8'd10));
		// address 9 holds the poison that only a wrong jump reaches
		appendWord(encodeImm(batPkg::OP_LDI, 3'd7, 8'hEE));
		appendWord(encodeImm(batPkg::OP_HLT, 3'd0, 8'd0));
		loadProgram();
		runProgram(1'b1, 8'hEE);
		checkEq("outValue", 16'(outValue), 16'(loops));
	endtask

	// host side of the contention test on the data region 0xC0..0xCF
	task automatic hostTraffic();
		batPkg::word_t data;
		batPkg::word_t got;
		batPkg::addr_t addr;
		for (int i = 0; i < 24; i++)
		begin
			addr = {4'hC, i[3:0]};
			data = batPkg::word_t'($urandom());
			hostWrite(addr, data);
			hostRead(addr, got);
			checkEq("hostRsp.rdData", got, data);
		end
	endtask

	task automatic hostContention();
		batPkg::data_t loops;
		loops = 8'd40;
		emitCountLoop(loops);
		appendWord(encodeImm(batPkg::OP_HLT, 3'd0, 8'd0));
		loadProgram();
		fork
			runProgram(1'b0, 8'h00);
			hostTraffic();
		join
		checkEq("outValue", 16'(outValue), 16'(loops));
	endtask

	task automatic randomAlu();
		batPkg::data_t model [batPkg::NUM_REGS];
		logic zeroFlag;
		batPkg::regIdx_t rd;
		batPkg::regIdx_t rs;
		batPkg::aluOp_t op;
		batPkg::data_t imm;
		batPkg::data_t res;
		batPkg::data_t expected;
		// every register starts from a random immediate
		for (int r = 0; r < batPkg::NUM_REGS; r++)
		begin
			imm = batPkg::data_t'($urandom());
			appendWord(encodeImm(batPkg::OP_LDI, batPkg::regIdx_t'(r), imm));
			model[r] = imm;
		end
		// gives the flag a known value before the random part
		appendWord(encodeAlu(batPkg::ALU_OR, 3'd0, 3'd0));
		zeroFlag = (model[0] == 8'h00);
		for (int n = 0; n < 20; n++)
		begin
			rd = batPkg::regIdx_t'($urandom());
			rs = batPkg::regIdx_t'($urandom());
			if ($urandom_range(3, 0) == 0)
			begin
				imm = batPkg::data_t'($urandom());
				appendWord(encodeImm(batPkg::OP_LDI, rd, imm));
				model[rd] = imm;
			end
			else
			begin
				op = aluOps[$urandom_range(6, 0)];
				appendWord(encodeAlu(op, rd, rs));
				res = aluExpect(op, model[rd], model[rs]);
				model[rd] = res;
				// MOV leaves the flag alone
				if (op != batPkg::ALU_MOV)
				begin
					zeroFlag = (res == 8'h00);
				end
			end
		end
		// the flag decides whether OUT gets one more increment
		appendWord(encodeImm(batPkg::OP_JZ, 3'd0, batPkg::addr_t'(progLen + 2)));
		appendWord(encodeAlu(batPkg::ALU_INC, 3'd7, 3'd0));
		appendWord(encodeImm(batPkg::OP_HLT, 3'd0, 8'd0));
		expected = zeroFlag ? model[7] : model[7] + 8'd1;
		loadProgram();
		runProgram(1'b0, 8'h00);
		checkEq("outValue", 16'(outValue), 16'(expected));
	endtask

	initial
	begin
		seedKick = $urandom(32'h3b5d64df);
		progLen = 0;
		rstN = 1'b0;
		run = 1'b0;
		hostReq = 1'b0;
		hostReqData = '0;
		repeat (16)
		begin
			@(posedge CLK);
		end
		rstN <= 1'b1;
		@(posedge CLK);
		afterReset();
		aluOperations();
		loadStore();
		jumpsAndLoop();
		hostContention();
		randomAlu();
		$display("Result: PASSED");
		$finish;
	end

endmodule
